/* src/lsu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// lsu package
// opcodes, funct3 codes, widths and the instruction word layout
//////////////////////////////////////////////////////////////////////

package lsu_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // datapath width and number of byte lanes
    localparam int xlen = 32;
    localparam int xbytes = xlen / 8;

    // register file geometry
    localparam int raddr_w = 5;
    localparam int nregs = 2 ** raddr_w;

    //////////////////////////////////////////////////////////////////////
    // opcodes and funct3 codes
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;

    // load sizes, bit 2 selects zero extension
    localparam logic [2:0] f3_lb = 3'b000;
    localparam logic [2:0] f3_lh = 3'b001;
    localparam logic [2:0] f3_lw = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // store sizes
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    //////////////////////////////////////////////////////////////////////
    // instruction word
    //////////////////////////////////////////////////////////////////////

    // loads carry a contiguous immediate (I-type), stores split it
    // around rs2 (S-type); opcode and funct3 sit at the same place in both
    typedef union packed {
        struct packed {
            logic [11:0]        imm12;
            logic [raddr_w-1:0] rs1;
            logic [2:0]         funct3;
            logic [raddr_w-1:0] rd;
            logic [6:0]         opcode;
        } i;
        struct packed {
            logic [6:0]         imm_hi;
            logic [raddr_w-1:0] rs2;
            logic [raddr_w-1:0] rs1;
            logic [2:0]         funct3;
            logic [4:0]         imm_lo;
            logic [6:0]         opcode;
        } s;
    } lsu_instr_u;

endpackage

/* src/lsu_memfy.sv */
//////////////////////////////////////////////////////////////////////
// load/store unit
// decodes RV32I loads and stores and runs them as Wishbone cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_memfy
    import lsu_pkg::*;
#(
    parameter int ADDRW = 10
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               srst,
    // instruction handshake
    input  logic               instr_valid,
    output logic               instr_ready,
    input  lsu_instr_u         instr,
    // register file queries
    output logic [raddr_w-1:0] rs1_addr,
    input  logic [xlen-1:0]    rs1_val,
    output logic [raddr_w-1:0] rs2_addr,
    input  logic [xlen-1:0]    rs2_val,
    // load write back
    output logic               rd_wr,
    output logic [raddr_w-1:0] rd_addr,
    output logic [xlen-1:0]    rd_val,
    output logic [xbytes-1:0]  rd_strb,
    // wishbone classic master
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output logic [ADDRW-3:0]   wb_adr,
    output logic [xlen-1:0]    wb_dat_w,
    output logic [xbytes-1:0]  wb_sel,
    input  logic [xlen-1:0]    wb_dat_r,
    input  logic               wb_ack
);

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // rotate left by whole bytes, store data towards its lanes
    function automatic logic [xlen-1:0] rotl_bytes(input logic [xlen-1:0] d,
                                                   input logic [1:0] off);
        logic [2*xlen-1:0] dd;
        dd = {d, d} << (8 * off);
        return dd[2*xlen-1:xlen];
    endfunction

    // rotate right by whole bytes, read lanes back to bit 0
    function automatic logic [xlen-1:0] rotr_bytes(input logic [xlen-1:0] d,
                                                   input logic [1:0] off);
        logic [2*xlen-1:0] dd;
        dd = {d, d} >> (8 * off);
        return dd[xlen-1:0];
    endfunction

    // byte mask of a store before it is moved to its offset
    function automatic logic [xbytes-1:0] store_mask(input logic [2:0] f3);
        case (f3)
            f3_sb:   return {{(xbytes-1){1'b0}}, 1'b1};
            f3_sh:   return {{(xbytes-2){1'b0}}, 2'b11};
            f3_sw:   return {xbytes{1'b1}};
            default: return '0;
        endcase
    endfunction

    // sign or zero extension of an aligned load
    function automatic logic [xlen-1:0] load_extend(input logic [2:0] f3,
                                                    input logic [xlen-1:0] d);
        case (f3)
            f3_lb:   return {{(xlen-8){d[7]}}, d[7:0]};
            f3_lbu:  return {{(xlen-8){1'b0}}, d[7:0]};
            f3_lh:   return {{(xlen-16){d[15]}}, d[15:0]};
            f3_lhu:  return {{(xlen-16){1'b0}}, d[15:0]};
            default: return d;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // decode and address generation
    //////////////////////////////////////////////////////////////////////

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 is_load;
    logic                 is_store;
    logic                 mem_access;
    logic [11:0]          imm;
    logic [xlen-1:0]      addr;
    logic [1:0]           offset;
    logic                 split;
    logic [2*xbytes-1:0]  sel_wide;
    logic                 accept;

    // control state
    logic                 req;
    logic                 split_r;
    logic                 phase2_r;
    // access payload
    logic [2:0]           funct3_r;
    logic [raddr_w-1:0]   rd_r;
    logic [1:0]           offset_r;
    logic [xbytes-1:0]    next_sel;
    logic [xbytes-1:0]    low_mask;

    // opcode and funct3 are common to both layouts
    assign opcode = instr.i.opcode;
    assign funct3 = instr.i.funct3;
    assign is_load = (opcode == opc_load);
    assign is_store = (opcode == opc_store);
    assign mem_access = is_load || is_store;

    assign rs1_addr = instr.i.rs1;
    assign rs2_addr = instr.s.rs2;

    // immediate layout follows the opcode
    assign imm = is_store ? {instr.s.imm_hi, instr.s.imm_lo} : instr.i.imm12;
    assign addr = rs1_val + {{(xlen-12){imm[11]}}, imm};
    assign offset = addr[1:0];

    // halfword at offset 3 or unaligned word touches the next word too
    assign split = ((funct3 == f3_lh || funct3 == f3_lhu) && is_load && offset == 2'd3) ||
                   (funct3 == f3_sh && is_store && offset == 2'd3) ||
                   ((funct3 == f3_lw || funct3 == f3_sw) && offset != 2'd0);

    // low half is phase one sel, high half spills into the next word
    assign sel_wide = {{xbytes{1'b0}}, store_mask(funct3)} << offset;

    assign accept = instr_valid && instr_ready;

    //////////////////////////////////////////////////////////////////////
    // two-phase control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            instr_ready <= 1'b0;
            req <= 1'b0;
            split_r <= 1'b0;
            phase2_r <= 1'b0;
        end else if (srst) begin
            instr_ready <= 1'b0;
            req <= 1'b0;
            split_r <= 1'b0;
            phase2_r <= 1'b0;
        end else begin
            if (req) begin
                if (wb_ack) begin
                    // first ack of a split keeps the cycle open
                    if (split_r && !phase2_r) begin
                        phase2_r <= 1'b1;
                    end else begin
                        req <= 1'b0;
                        phase2_r <= 1'b0;
                        instr_ready <= 1'b1;
                    end
                end
            end else if (accept && mem_access) begin
                instr_ready <= 1'b0;
                req <= 1'b1;
                split_r <= split;
                phase2_r <= 1'b0;
            end else begin
                // idle, other opcodes fall through here and are dropped
                instr_ready <= 1'b1;
            end
        end
    end

    // bus payload, loaded at acceptance
    always_ff @(posedge aclk) begin
        if (accept && mem_access) begin
            wb_we <= is_store;
            wb_adr <= addr[ADDRW-1:2];
            wb_dat_w <= rotl_bytes(rs2_val, offset);
            // reads take every lane
            wb_sel <= is_store ? sel_wide[xbytes-1:0] : {xbytes{1'b1}};
            next_sel <= is_store ? sel_wide[2*xbytes-1:xbytes] : {xbytes{1'b1}};
            funct3_r <= funct3;
            rd_r <= instr.i.rd;
            offset_r <= offset;
        end else if (req && wb_ack && split_r && !phase2_r) begin
            // second word, wraps with the address space
            wb_adr <= wb_adr + 1'b1;
            wb_sel <= next_sel;
        end
    end

    assign wb_cyc = req;
    assign wb_stb = req;

    //////////////////////////////////////////////////////////////////////
    // load write back
    //////////////////////////////////////////////////////////////////////

    // one write per ack
    assign rd_wr = req && wb_ack && !wb_we;
    assign rd_addr = rd_r;
    assign rd_val = load_extend(funct3_r, rotr_bytes(wb_dat_r, offset_r));

    // split: low bytes of rd from the first word, the rest from the second
    assign low_mask = {xbytes{1'b1}} >> offset_r;
    assign rd_strb = !split_r ? {xbytes{1'b1}} :
                     phase2_r ? ~low_mask : low_mask;

endmodule

/* src/lsu_regfile.sv */
//////////////////////////////////////////////////////////////////////
// register file
// 32 registers, two query ports, strobed load write and host port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_regfile
    import lsu_pkg::*;
(
    input  logic               aclk,
    input  logic               aresetn,
    // queries from the unit
    input  logic [raddr_w-1:0] rs1_addr,
    output logic [xlen-1:0]    rs1_val,
    input  logic [raddr_w-1:0] rs2_addr,
    output logic [xlen-1:0]    rs2_val,
    // load write back
    input  logic               rd_wr,
    input  logic [raddr_w-1:0] rd_addr,
    input  logic [xlen-1:0]    rd_val,
    input  logic [xbytes-1:0]  rd_strb,
    // host access
    input  logic               host_wr,
    input  logic [raddr_w-1:0] host_addr,
    input  logic [xlen-1:0]    host_wdata,
    output logic [xlen-1:0]    host_rdata
);

    logic [xlen-1:0] regs [nregs];

    // x0 is cleared here and never written, so it reads zero
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (rd_wr && rd_addr != '0) begin
                for (int b = 0; b < xbytes; b++) begin
                    if (rd_strb[b]) begin
                        regs[rd_addr][8*b +: 8] <= rd_val[8*b +: 8];
                    end
                end
            end
            // host writes replace the whole word
            if (host_wr && host_addr != '0) begin
                regs[host_addr] <= host_wdata;
            end
        end
    end

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];
    assign host_rdata = regs[host_addr];

endmodule

/* src/lsu_data_ram.sv */
//////////////////////////////////////////////////////////////////////
// data RAM
// word wide Wishbone classic slave with byte selects and one wait state
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_data_ram
    import lsu_pkg::*;
#(
    parameter int ADDRW = 10
) (
    input  logic              aclk,
    input  logic              aresetn,
    // wishbone classic slave
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDRW-3:0]  wb_adr,
    input  logic [xlen-1:0]   wb_dat_w,
    input  logic [xbytes-1:0] wb_sel,
    output logic [xlen-1:0]   wb_dat_r,
    output logic              wb_ack
);

    // word count from the byte address width
    localparam int depth = 2 ** (ADDRW - 2);

    logic [xlen-1:0] mem [depth];
    logic            req_new;

    // a request not yet acknowledged, so ack never runs two cycles
    assign req_new = wb_cyc && wb_stb && !wb_ack;

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req_new;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // write and read happen on the edge that raises ack
    always_ff @(posedge aclk) begin
        if (req_new) begin
            if (wb_we) begin
                for (int b = 0; b < xbytes; b++) begin
                    if (wb_sel[b]) begin
                        mem[wb_adr][8*b +: 8] <= wb_dat_w[8*b +: 8];
                    end
                end
            end
            // a write returns the old word, the master ignores it
            wb_dat_r <= mem[wb_adr];
        end
    end

endmodule

/* src/lsu_core.sv */
//////////////////////////////////////////////////////////////////////
// load/store subsystem top
// ties the load/store unit to its register file and data RAM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_core
    import lsu_pkg::*;
#(
    parameter int ADDRW = 10
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               srst,
    // instruction handshake
    input  logic               instr_valid,
    output logic               instr_ready,
    input  logic [31:0]        instr,
    // host register port
    input  logic               host_wr,
    input  logic [raddr_w-1:0] host_addr,
    input  logic [xlen-1:0]    host_wdata,
    output logic [xlen-1:0]    host_rdata
);

    // register file queries and write back
    logic [raddr_w-1:0] rs1_addr;
    logic [raddr_w-1:0] rs2_addr;
    logic [xlen-1:0]    rs1_val;
    logic [xlen-1:0]    rs2_val;
    logic               rd_wr;
    logic [raddr_w-1:0] rd_addr;
    logic [xlen-1:0]    rd_val;
    logic [xbytes-1:0]  rd_strb;

    // wishbone between unit and RAM
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [ADDRW-3:0]   wb_adr;
    logic [xlen-1:0]    wb_dat_w;
    logic [xbytes-1:0]  wb_sel;
    logic [xlen-1:0]    wb_dat_r;
    logic               wb_ack;

    lsu_memfy #(
        .ADDRW (ADDRW)
    ) lsu_memfy_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .rs2_addr    (rs2_addr),
        .rs2_val     (rs2_val),
        .rd_wr       (rd_wr),
        .rd_addr     (rd_addr),
        .rd_val      (rd_val),
        .rd_strb     (rd_strb),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    lsu_regfile lsu_regfile_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .rs2_addr   (rs2_addr),
        .rs2_val    (rs2_val),
        .rd_wr      (rd_wr),
        .rd_addr    (rd_addr),
        .rd_val     (rd_val),
        .rd_strb    (rd_strb),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    lsu_data_ram #(
        .ADDRW (ADDRW)
    ) lsu_data_ram_inst (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

/* testbench/lsu_core_checker.sv */
//////////////////////////////////////////////////////////////////////
// lsu_core assertions
// wishbone classic and instruction handshake rules, bound into the top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_core_checker
    import lsu_pkg::*;
#(
    parameter int ADDRW = 10
) (
    input logic              aclk,
    input logic              aresetn,
    input logic              instr_ready,
    input logic              wb_cyc,
    input logic              wb_stb,
    input logic              wb_we,
    input logic [ADDRW-3:0]  wb_adr,
    input logic [xlen-1:0]   wb_dat_w,
    input logic [xbytes-1:0] wb_sel,
    input logic              wb_ack
);

    // strobe only inside a bus cycle
    assert property (@(posedge aclk) disable iff (!aresetn) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // a pending request holds its payload until ack
    assert property (@(posedge aclk) disable iff (!aresetn)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) &&
                                 $stable(wb_sel) && $stable(wb_dat_w)))
        else $error("wishbone payload changed before ack");

    // single cycle ack
    assert property (@(posedge aclk) disable iff (!aresetn) wb_ack |=> !wb_ack)
        else $error("wb_ack held longer than one cycle");

    // no new instruction while the bus is busy
    assert property (@(posedge aclk) disable iff (!aresetn) wb_cyc |-> !instr_ready)
        else $error("instr_ready high during a bus cycle");

endmodule

bind lsu_core lsu_core_checker #(
    .ADDRW (ADDRW)
) lsu_core_checker_inst (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .instr_ready (instr_ready),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_sel      (wb_sel),
    .wb_ack      (wb_ack)
);

/* testbench/lsu_core_tb.sv */
//////////////////////////////////////////////////////////////////////
// lsu_core testbench
// byte level memory model, checks registers through the host port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_core_tb
    import lsu_pkg::*;
;

    localparam int ADDRW = 10;
    localparam int mem_bytes = 2 ** ADDRW;
    localparam int wait_limit = 64;

    logic        aclk;
    logic        aresetn;
    logic        srst;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic        host_wr;
    logic [4:0]  host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;

    // reference state
    logic [7:0]  ref_mem [mem_bytes];
    logic [31:0] ref_regs [32];

    // compare request towards the checking process
    logic        cmp_en;
    logic [4:0]  cmp_reg;
    logic [31:0] cmp_exp;
    int          check_count;
    int          error_count;

    lsu_core #(
        .ADDRW (ADDRW)
    ) lsu_core_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .host_wr     (host_wr),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata)
    );

    always #20 aclk = ~aclk;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // byte address wraps with the RAM size
    function automatic logic [7:0] mem_byte(input logic [31:0] addr);
        return ref_mem[addr[ADDRW-1:0]];
    endfunction

    // little endian gather, then extension by size and signedness
    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] v;
        v = {mem_byte(addr + 3), mem_byte(addr + 2), mem_byte(addr + 1), mem_byte(addr)};
        case (f3)
            f3_lb:   return {{24{v[7]}}, v[7:0]};
            f3_lbu:  return {24'h0, v[7:0]};
            f3_lh:   return {{16{v[15]}}, v[15:0]};
            f3_lhu:  return {16'h0, v[15:0]};
            default: return v;
        endcase
    endfunction

    // a store writes its own bytes only, possibly into the next word
    task automatic ref_store(input logic [2:0] f3, input logic [31:0] addr,
                             input logic [31:0] data);
        int          n;
        int          k;
        logic [31:0] a;
        n = (f3 == f3_sb) ? 1 : (f3 == f3_sh) ? 2 : 4;
        for (k = 0; k < n; k++) begin
            a = addr + k;
            ref_mem[a[ADDRW-1:0]] = data[8*k +: 8];
        end
    endtask

    // initial RAM image, each lane tied to the word address
    function automatic logic [31:0] fill_word(input int w);
        return (w * 32'h0101_0101) ^ 32'h8f3c_5a17;
    endfunction

    function automatic logic [2:0] load_code(input int sel);
        case (sel)
            0:       return f3_lb;
            1:       return f3_lh;
            2:       return f3_lw;
            3:       return f3_lbu;
            default: return f3_lhu;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // comparing process
    //////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        if (cmp_en) begin
            check_count++;
            if (host_rdata !== cmp_exp) begin
                error_count++;
                $display("** Error: host_rdata (x%0d) = 0x%08h, expected 0x%08h",
                         cmp_reg, host_rdata, cmp_exp);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////////////////////////

    task automatic end_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        error_count++;
        end_run();
    endtask

    task automatic wait_ready();
        int t;
        for (t = 0; t < wait_limit; t++) begin
            @(posedge aclk);
            if (instr_ready) break;
        end
        if (t == wait_limit) timeout_fail("instr_ready did not return after an access");
    endtask

    // present an instruction, hold it to the handshake, then wait for the end
    task automatic issue(input logic [31:0] w);
        int t;
        @(posedge aclk);
        instr <= w;
        instr_valid <= 1'b1;
        for (t = 0; t < wait_limit; t++) begin
            @(posedge aclk);
            if (instr_ready) break;
        end
        instr_valid <= 1'b0;
        if (t == wait_limit) timeout_fail("instruction was never accepted");
        wait_ready();
    endtask

    task automatic host_write(input logic [4:0] r, input logic [31:0] d);
        @(posedge aclk);
        host_wr <= 1'b1;
        host_addr <= r;
        host_wdata <= d;
        @(posedge aclk);
        host_wr <= 1'b0;
        if (r != 5'd0) ref_regs[r] = d;
    endtask

    task automatic check_reg(input logic [4:0] r);
        @(posedge aclk);
        host_addr <= r;
        cmp_reg <= r;
        cmp_exp <= ref_regs[r];
        cmp_en <= 1'b1;
        @(posedge aclk);
        cmp_en <= 1'b0;
    endtask

    task automatic check_all();
        int r;
        for (r = 0; r < 32; r++) check_reg(5'(r));
    endtask

    task automatic do_store(input logic [2:0] f3, input logic [4:0] rs2,
                            input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = ref_regs[rs1] + {{20{imm[11]}}, imm};
        issue({imm[11:5], rs2, rs1, f3, imm[4:0], opc_store});
        ref_store(f3, addr, ref_regs[rs2]);
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = ref_regs[rs1] + {{20{imm[11]}}, imm};
        issue({imm, rs1, f3, rd, opc_load});
        if (rd != 5'd0) ref_regs[rd] = load_value(f3, addr);
        check_reg(rd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          i;
        int          off;
        int          f;
        int          sel;
        logic [11:0] imm;
        void'($urandom(86853));
        aclk = 1'b0;
        aresetn = 1'b0;
        srst = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        host_wr = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        cmp_en = 1'b0;
        cmp_reg = '0;
        cmp_exp = '0;
        check_count = 0;
        error_count = 0;
        for (i = 0; i < 32; i++) ref_regs[i] = '0;
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;
        wait_ready();

        // fill the whole RAM with x0 as base
        for (i = 0; i < mem_bytes / 4; i++) begin
            host_write(5'd2, fill_word(i));
            do_store(f3_sw, 5'd2, 5'd0, 12'(4 * i));
        end

        // aligned word round trip
        host_write(5'd1, 32'h0000_0100);
        host_write(5'd3, $urandom);
        do_store(f3_sw, 5'd3, 5'd1, 12'h010);
        do_load(f3_lw, 5'd4, 5'd1, 12'h010);

        // byte and halfword into preloaded words
        do_store(f3_sb, 5'd3, 5'd1, 12'h021);
        do_store(f3_sh, 5'd3, 5'd1, 12'h026);
        do_load(f3_lw, 5'd5, 5'd1, 12'h020);
        do_load(f3_lw, 5'd5, 5'd1, 12'h024);

        // narrow loads at every offset, mixed sign bits
        host_write(5'd3, 32'h8f7e_01f0);
        do_store(f3_sw, 5'd3, 5'd1, 12'h040);
        host_write(5'd3, 32'h12c3_44e5);
        do_store(f3_sw, 5'd3, 5'd1, 12'h044);
        for (off = 0; off < 4; off++) begin
            for (f = 0; f < 5; f++) begin
                if (f != 2) do_load(load_code(f), 5'd6, 5'd1, 12'(64 + off));
            end
        end

        // word accesses across a boundary, then both words read back
        for (off = 1; off < 4; off++) begin
            host_write(5'd7, $urandom);
            do_store(f3_sw, 5'd7, 5'd1, 12'(128 + off * 17));
            do_load(f3_lw, 5'd8, 5'd1, 12'(128 + off * 17));
            do_load(f3_lw, 5'd9, 5'd1, 12'(128 + off * 16));
            do_load(f3_lw, 5'd9, 5'd1, 12'(132 + off * 16));
        end
        host_write(5'd7, $urandom);
        do_store(f3_sh, 5'd7, 5'd1, 12'h0b3);
        do_load(f3_lh, 5'd8, 5'd1, 12'h0b3);
        do_load(f3_lhu, 5'd8, 5'd1, 12'h0b3);
        do_load(f3_lw, 5'd9, 5'd1, 12'h0b0);
        do_load(f3_lw, 5'd9, 5'd1, 12'h0b4);

        // negative offsets and wrap past the top of the RAM
        host_write(5'd1, 32'h0000_0200);
        do_store(f3_sw, 5'd3, 5'd1, 12'hffc);
        do_load(f3_lw, 5'd10, 5'd1, 12'hffc);
        do_load(f3_lb, 5'd10, 5'd1, 12'hf01);
        host_write(5'd11, 32'hffff_fffe);
        do_load(f3_lw, 5'd12, 5'd11, 12'h000);
        host_write(5'd11, 32'h0000_03fd);
        do_store(f3_sw, 5'd3, 5'd11, 12'h000);
        do_load(f3_lw, 5'd12, 5'd0, 12'h3fc);
        do_load(f3_lw, 5'd12, 5'd0, 12'h000);
        host_write(5'd11, 32'h0000_03f0);
        do_load(f3_lh, 5'd12, 5'd11, 12'h013);

        // x0 stays zero, other opcodes are dropped
        do_load(f3_lw, 5'd0, 5'd1, 12'h010);
        issue(32'h00a0_8093);
        issue(32'h0020_81b3);
        check_all();

        // synchronous clear while idle
        @(posedge aclk);
        srst <= 1'b1;
        @(posedge aclk);
        srst <= 1'b0;
        @(posedge aclk);
        check_count++;
        if (instr_ready) begin
            error_count++;
            $display("** Error: instr_ready = 0x%0h after srst, expected 0x0", instr_ready);
        end
        wait_ready();
        do_load(f3_lw, 5'd4, 5'd1, 12'hffc);

        // random mix with a full 32-bit base
        for (i = 0; i < 200; i++) begin
            host_write(5'd13, $urandom);
            imm = 12'($urandom);
            if ($urandom % 2 == 0) begin
                host_write(5'd14, $urandom);
                sel = $urandom % 3;
                do_store((sel == 0) ? f3_sb : (sel == 1) ? f3_sh : f3_sw,
                         5'd14, 5'd13, imm);
            end else begin
                sel = $urandom % 5;
                do_load(load_code(sel), 5'($urandom % 32), 5'd13, imm);
            end
        end
        check_all();

        // every word of the RAM against the byte model
        for (i = 0; i < mem_bytes / 4; i++) begin
            do_load(f3_lw, 5'd15, 5'd0, 12'(4 * i));
        end

        // let the last compare land
        repeat (2) @(posedge aclk);
        end_run();
    end

endmodule

/* lsu_core.f */
src/lsu_pkg.sv
src/lsu_memfy.sv
src/lsu_regfile.sv
src/lsu_data_ram.sv
src/lsu_core.sv
testbench/lsu_core_checker.sv
testbench/lsu_core_tb.sv

/* Makefile */
# Verilator build and run of the lsu_core testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lsu_core_tb
FILELIST = lsu_core.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless the log reports a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
